//--- common/burst_if.sv
`timescale 1ns/10ps
`default_nettype none

// Link between the DDR arbiter and its beat counter
interface burst_if #(
    parameter int BW = mr_pkg::BURST_W
);

    // Granted read accepted by the DDR controller
    logic          rd_take;
    // One write beat accepted
    logic          wr_take;
    // Burst length of the granted request
    logic [BW-1:0] burstcnt;
    // Read data beat returned
    logic          dout_ready;
    // Nothing outstanding
    logic          burst_idle;

    modport fsm (
        output rd_take,
        output wr_take,
        output burstcnt,
        input  burst_idle
    );

    modport cnt (
        input  rd_take,
        input  wr_take,
        input  burstcnt,
        input  dout_ready,
        output burst_idle
    );

endinterface

`default_nettype wire

//--- common/mr_pkg.sv
`default_nettype none

package mr_pkg;

    // Bus widths
    localparam int STATUS_W = 64;
    localparam int DDR_AW   = 29;
    localparam int DDR_DW   = 64;
    localparam int BURST_W  = 8;
    localparam int USER_W   = 7;
    localparam int HDMI_W_W = 12;

    // Only a full HD output leaves room for the vertical crop
    localparam logic [HDMI_W_W-1:0] HDMI_FULL_W = 12'd1920;
    localparam logic [HDMI_W_W-1:0] HDMI_FULL_H = 12'd1080;

    // Lines removed when the crop is active
    localparam logic [HDMI_W_W-1:0] CROP_LINES = 12'd216;

    // Offset options 6 and up wrap to negative offsets
    localparam logic [4:0] CROP_WRAP      = 5'd24;
    localparam logic [3:0] CROP_VCOPT_MAX = 4'd6;

    // OSD status word bit positions
    localparam int ST_SCANFX_LO     = 3;
    localparam int ST_SCANFX_HI     = 5;
    localparam int ST_UART_EN       = 38;
    localparam int ST_CROP_EN       = 41;
    localparam int ST_VCOPT_LO      = 42;
    localparam int ST_VCOPT_HI      = 45;
    localparam int ST_CROP_SCALE_LO = 46;
    localparam int ST_CROP_SCALE_HI = 47;

    // User port lines idle high
    localparam logic [USER_W-1:0] USER_IDLE = '1;

endpackage

`default_nettype wire

//--- ddr_arb/ddr_arb_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_arb_fsm #(
    parameter int AW = mr_pkg::DDR_AW,
    parameter int BW = mr_pkg::BURST_W
) (
    input  wire                         clk_sys,
    input  wire                         rst_n,
    input  wire                         downloading,
    // Fast ROM loader
    input  wire [BW-1:0]                ddrld_burstcnt,
    input  wire [AW-1:0]                ddrld_addr,
    input  wire                         ddrld_rd,
    output logic                        ddrld_busy,
    // Frame buffer rotation
    input  wire [BW-1:0]                rot_burstcnt,
    input  wire [AW-1:0]                rot_addr,
    input  wire                         rot_rd,
    input  wire                         rot_we,
    input  wire [mr_pkg::DDR_DW/8-1:0]  rot_be,
    output logic                        rot_busy,
    // DDR3 controller
    input  wire                         ddram_busy,
    output logic [BW-1:0]               ddram_burstcnt,
    output logic [AW-1:0]               ddram_addr,
    output logic                        ddram_rd,
    output logic                        ddram_we,
    output logic [mr_pkg::DDR_DW/8-1:0] ddram_be,
    burst_if.fsm                        bif
);

    localparam logic OWN_ROT  = 1'b0;
    localparam logic OWN_LOAD = 1'b1;

    logic owner;
    logic want;

    assign want = downloading ? OWN_LOAD : OWN_ROT;

    // Granted port goes straight through while the other one is stalled
    always_comb begin
        if (owner == OWN_LOAD) begin
            ddram_burstcnt = ddrld_burstcnt;
            ddram_addr     = ddrld_addr;
            ddram_rd       = ddrld_rd;
            ddram_we       = 1'b0;
            ddram_be       = '1;
            ddrld_busy     = ddram_busy;
            rot_busy       = 1'b1;
        end else begin
            ddram_burstcnt = rot_burstcnt;
            ddram_addr     = rot_addr;
            ddram_rd       = rot_rd;
            ddram_we       = rot_we;
            ddram_be       = rot_be;
            ddrld_busy     = 1'b1;
            rot_busy       = ddram_busy;
        end
    end

    assign bif.rd_take  = ddram_rd & ~ddram_busy;
    assign bif.wr_take  = ddram_we & ~ddram_busy;
    assign bif.burstcnt = ddram_burstcnt;

    // Hand over only between bursts
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            owner <= OWN_ROT;
        end else if (want != owner && bif.burst_idle && !bif.rd_take && !bif.wr_take) begin
            owner <= want;
        end
    end

    a_rd_we_excl: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        !(ddram_rd && ddram_we)
    );

endmodule

`default_nettype wire

//--- ddr_arb/ddr_burst_cnt.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_burst_cnt #(
    parameter int BW = mr_pkg::BURST_W
) (
    input  wire  clk_sys,
    input  wire  rst_n,
    burst_if.cnt bif
);

    logic [BW-1:0] cnt;
    logic          cnt_zero;
    logic          dec;

    assign cnt_zero = (cnt == '0);

    // Later write beats and returned read beats count down
    assign dec = (bif.wr_take && !cnt_zero) || (bif.dout_ready && !bif.rd_take);

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (bif.rd_take) begin
            cnt <= bif.burstcnt;
        end else if (bif.wr_take && cnt_zero) begin
            // First write beat is already on the bus
            cnt <= bif.burstcnt - 1'b1;
        end else if (dec) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign bif.burst_idle = cnt_zero;

    // Read data only comes back for a burst in flight
    a_no_underflow: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        dec |-> !cnt_zero
    );

endmodule

`default_nettype wire

//--- dv/tb_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 8
) (
    output logic clk_sys,
    output logic rst_n
);

    initial begin
        clk_sys = 1'b0;
        forever #(PERIOD / 2) clk_sys = ~clk_sys;
    end

    // Release on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_sys);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- dv/tb_mr_frame.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mr_frame;

    localparam int AW  = mr_pkg::DDR_AW;
    localparam int BW  = mr_pkg::BURST_W;
    localparam int BEW = mr_pkg::DDR_DW / 8;
    localparam int HW  = mr_pkg::HDMI_W_W;
    localparam int UW  = mr_pkg::USER_W;

    localparam int N_CROP  = 200;
    localparam int N_VCOPT = 16;
    localparam int N_USER  = 64;
    localparam int N_MOUSE = 64;
    localparam int N_ARB   = 80;
    // Reset, all tests, three settle cycles per test, then some slack
    localparam int WD_CYCLES = 8 + N_CROP + N_VCOPT + N_USER + N_MOUSE + N_ARB + 5 * 3 + 100;

    typedef struct packed {
        logic [BW-1:0]  burstcnt;
        logic [AW-1:0]  addr;
        logic           rd;
        logic           we;
        logic [BEW-1:0] be;
        logic           ld_busy;
        logic           rot_busy;
    } ddr_exp_t;

    logic clk_sys;
    logic rst_n;
    logic [mr_pkg::STATUS_W-1:0] status;
    logic [HW-1:0]  hdmi_width;
    logic [HW-1:0]  hdmi_height;
    logic           direct_video;
    logic           force_scan2x;
    logic           rotate_en;
    logic           crop_ok;
    logic [HW-1:0]  crop_size;
    logic [4:0]     crop_off;
    logic [24:0]    ps2_mouse;
    logic [8:0]     mouse_dx;
    logic [8:0]     mouse_dy;
    logic [7:0]     mouse_f;
    logic           mouse_st;
    logic [UW-1:0]  user_in;
    logic           game_tx;
    logic           cheat_tx;
    logic [UW-1:0]  user_out;
    logic           game_rx;
    logic           downloading;
    logic [BW-1:0]  ddrld_burstcnt;
    logic [AW-1:0]  ddrld_addr;
    logic           ddrld_rd;
    logic           ddrld_busy;
    logic [BW-1:0]  rot_burstcnt;
    logic [AW-1:0]  rot_addr;
    logic           rot_rd;
    logic           rot_we;
    logic [BEW-1:0] rot_be;
    logic           rot_busy;
    logic [BW-1:0]  ddram_burstcnt;
    logic [AW-1:0]  ddram_addr;
    logic           ddram_rd;
    logic           ddram_we;
    logic [BEW-1:0] ddram_be;
    logic           ddram_busy;
    logic           ddram_dout_ready;

    // Expected values for the next falling edge
    logic          e_ok;
    logic [HW-1:0] e_size;
    logic [4:0]    e_off;
    logic [UW-1:0] e_user;
    logic          e_st;
    logic          prev_b24;
    logic [25:0]   e_mouse;
    logic          m_seen = 1'b0;
    logic          own_load;
    logic [BW-1:0] m_cnt;
    logic          take;
    ddr_exp_t      e_ddr;

    logic [31:0] lfsr_state = 32'h19;
    int err_cnt  = 0;
    int n_tests  = 0;
    int n_failed = 0;

    tb_clkgen #(.PERIOD(40), .RST_CYCLES(8)) u_clkgen (
        .clk_sys ( clk_sys ),
        .rst_n   ( rst_n   )
    );

    mr_frame #(.AW(AW), .BW(BW)) i_dut (.*);

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic crop_ref(input logic [63:0] st, input logic [HW-1:0] w,
                                      input logic [HW-1:0] h, input logic dv,
                                      input logic fs, input logic rot);
        return (w == 12'd1920) && (h == 12'd1080) &&
               (st[mr_pkg::ST_SCANFX_HI:mr_pkg::ST_SCANFX_LO] == 3'd0) && !fs &&
               (st[mr_pkg::ST_CROP_SCALE_HI:mr_pkg::ST_CROP_SCALE_LO] == 2'd0) &&
               !dv && !rot;
    endfunction

    function automatic logic [4:0] off_ref(input logic [3:0] vcopt);
        int v;
        v = 2 * vcopt;
        if (vcopt >= 6) begin
            v = v - 24;
        end
        return v[4:0];
    endfunction

    function automatic logic [UW-1:0] user_ref(input logic en, input logic tx, input logic ctx);
        return en ? {{(UW-1){1'b1}}, tx & ctx} : {UW{1'b1}};
    endfunction

    function automatic logic rx_ref(input logic en, input logic [UW-1:0] ui);
        return en ? ui[1] : 1'b1;
    endfunction

    // Packed as {dx, dy, flags} with sign bits from the flag byte
    function automatic logic [25:0] mouse_ref(input logic [23:0] pkt);
        return {pkt[4], pkt[15:8], pkt[5], pkt[23:16], pkt[7:0]};
    endfunction

    function automatic ddr_exp_t route_ref(input logic load);
        ddr_exp_t r;
        if (load) begin
            r.burstcnt = ddrld_burstcnt;
            r.addr     = ddrld_addr;
            r.rd       = ddrld_rd;
            r.we       = 1'b0;
            r.be       = '1;
            r.ld_busy  = ddram_busy;
            r.rot_busy = 1'b1;
        end else begin
            r.burstcnt = rot_burstcnt;
            r.addr     = rot_addr;
            r.rd       = rot_rd;
            r.we       = rot_we;
            r.be       = rot_be;
            r.ld_busy  = 1'b1;
            r.rot_busy = ddram_busy;
        end
        return r;
    endfunction

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_size(input string name, input logic [HW-1:0] got,
                              input logic [HW-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_off(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_user(input string name, input logic [UW-1:0] got,
                              input logic [UW-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_move(input string name, input logic [8:0] got, input logic [8:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input string name, input logic [AW-1:0] got,
                              input logic [AW-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_burst(input string name, input logic [BW-1:0] got,
                               input logic [BW-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    // Registered outputs are compared against what was predicted one edge earlier
    always @(negedge clk_sys) begin
        if (!rst_n) begin
            e_ok     = 1'b0;
            e_size   = '0;
            e_off    = '0;
            e_user   = {UW{1'b1}};
            e_st     = 1'b0;
            prev_b24 = 1'b0;
            own_load = 1'b0;
            m_cnt    = '0;
        end else begin
            check_flag("crop_ok", crop_ok, e_ok);
            check_size("crop_size", crop_size, e_size);
            check_off("crop_off", crop_off, e_off);
            check_user("user_out", user_out, e_user);
            check_flag("game_rx", game_rx, rx_ref(status[mr_pkg::ST_UART_EN], user_in));
            check_flag("mouse_st", mouse_st, e_st);
            if (m_seen) begin
                check_move("mouse_dx", mouse_dx, e_mouse[25:17]);
                check_move("mouse_dy", mouse_dy, e_mouse[16:8]);
                check_byte("mouse_f", mouse_f, e_mouse[7:0]);
            end
            e_ddr = route_ref(own_load);
            check_burst("ddram_burstcnt", ddram_burstcnt, e_ddr.burstcnt);
            check_addr("ddram_addr", ddram_addr, e_ddr.addr);
            check_flag("ddram_rd", ddram_rd, e_ddr.rd);
            check_flag("ddram_we", ddram_we, e_ddr.we);
            check_byte("ddram_be", ddram_be, e_ddr.be);
            check_flag("ddrld_busy", ddrld_busy, e_ddr.ld_busy);
            check_flag("rot_busy", rot_busy, e_ddr.rot_busy);

            // Size uses the crop_ok that is registered now
            e_size = (e_ok && status[mr_pkg::ST_CROP_EN]) ? 12'd216 : '0;
            e_ok   = crop_ref(status, hdmi_width, hdmi_height, direct_video,
                              force_scan2x, rotate_en);
            e_off  = off_ref(status[mr_pkg::ST_VCOPT_HI:mr_pkg::ST_VCOPT_LO]);
            e_user = user_ref(status[mr_pkg::ST_UART_EN], game_tx, cheat_tx);
            e_st     = ps2_mouse[24] ^ prev_b24;
            prev_b24 = ps2_mouse[24];
            if (e_st) begin
                e_mouse = mouse_ref(ps2_mouse[23:0]);
                m_seen  = 1'b1;
            end

            // Arbiter model hands over only with nothing in flight
            take = (e_ddr.rd || e_ddr.we) && !ddram_busy;
            if (own_load != downloading && m_cnt == '0 && !take) begin
                own_load = downloading;
            end
            if (e_ddr.rd && !ddram_busy) begin
                m_cnt = e_ddr.burstcnt;
            end else if (e_ddr.we && !ddram_busy) begin
                m_cnt = (m_cnt == '0) ? e_ddr.burstcnt - 8'd1 : m_cnt - 8'd1;
            end else if (ddram_dout_ready && m_cnt != '0) begin
                m_cnt = m_cnt - 8'd1;
            end
        end
    end

    task automatic test_crop();
        logic [63:0] st;
        for (int i = 0; i < N_CROP; i++) begin
            st = rand_bits(64);
            // Clear the scaler fields often enough to see the crop allowed
            if (rand_bits(1) != 0) begin
                st[mr_pkg::ST_SCANFX_HI:mr_pkg::ST_SCANFX_LO] = '0;
                st[mr_pkg::ST_CROP_SCALE_HI:mr_pkg::ST_CROP_SCALE_LO] = '0;
            end
            status <= st;
            if (rand_bits(1) != 0) begin
                hdmi_width  <= 12'd1920;
                hdmi_height <= 12'd1080;
            end else begin
                hdmi_width  <= rand_bits(HW);
                hdmi_height <= rand_bits(HW);
            end
            direct_video <= (rand_bits(2) == 0);
            force_scan2x <= (rand_bits(2) == 0);
            rotate_en    <= (rand_bits(2) == 0);
            @(posedge clk_sys);
        end
    endtask

    task automatic test_vcopt();
        logic [63:0] st;
        for (int v = 0; v < N_VCOPT; v++) begin
            st = rand_bits(64);
            st[mr_pkg::ST_VCOPT_HI:mr_pkg::ST_VCOPT_LO] = v;
            status <= st;
            @(posedge clk_sys);
        end
    endtask

    task automatic test_user();
        for (int i = 0; i < N_USER; i++) begin
            status[mr_pkg::ST_UART_EN] <= rand_bits(1);
            game_tx  <= rand_bits(1);
            cheat_tx <= rand_bits(1);
            user_in  <= rand_bits(UW);
            @(posedge clk_sys);
        end
    endtask

    task automatic test_mouse();
        logic        tgl;
        logic [23:0] pkt;
        for (int i = 0; i < N_MOUSE; i++) begin
            // Some packets keep bit 24 to show that nothing is taken then
            tgl = (rand_bits(2) != 0);
            pkt = rand_bits(24);
            ps2_mouse <= {ps2_mouse[24] ^ tgl, pkt};
            @(posedge clk_sys);
        end
    endtask

    task automatic test_arb();
        int         waited;
        logic [1:0] kind;
        // Controller stays busy so no burst starts
        ddram_busy <= 1'b1;
        for (int i = 0; i < 16; i++) begin
            kind = rand_bits(2);
            rot_rd         <= (kind == 2'd1);
            rot_we         <= (kind == 2'd2);
            rot_addr       <= rand_bits(AW);
            rot_burstcnt   <= rand_bits(BW);
            rot_be         <= rand_bits(BEW);
            ddrld_rd       <= rand_bits(1);
            ddrld_addr     <= rand_bits(AW);
            ddrld_burstcnt <= rand_bits(BW);
            @(posedge clk_sys);
        end
        ddram_busy   <= 1'b0;
        ddrld_rd     <= 1'b0;
        rot_we       <= 1'b0;
        rot_rd       <= 1'b1;
        rot_burstcnt <= 8'd4;
        @(posedge clk_sys);
        rot_rd      <= 1'b0;
        downloading <= 1'b1;
        repeat (3) @(posedge clk_sys);
        for (int i = 0; i < 4; i++) begin
            ddram_dout_ready <= 1'b1;
            @(negedge clk_sys);
            if (rot_busy) begin
                $display("arbiter handed over with %0d of 4 read beats returned", i);
                err_cnt++;
            end
            @(posedge clk_sys);
            ddram_dout_ready <= 1'b0;
            @(posedge clk_sys);
        end
        waited = 0;
        @(negedge clk_sys);
        while (!rot_busy && waited < 8) begin
            @(negedge clk_sys);
            waited++;
        end
        if (!rot_busy) begin
            $display("arbiter did not grant the loader after the read burst drained");
            err_cnt++;
        end
        @(posedge clk_sys);
        // Rotation writes must stay off the bus while the loader owns it
        ddram_busy <= 1'b1;
        for (int i = 0; i < 16; i++) begin
            ddrld_rd       <= rand_bits(1);
            ddrld_addr     <= rand_bits(AW);
            ddrld_burstcnt <= rand_bits(BW);
            rot_we         <= rand_bits(1);
            rot_addr       <= rand_bits(AW);
            @(posedge clk_sys);
        end
        ddrld_rd    <= 1'b0;
        rot_we      <= 1'b0;
        ddram_busy  <= 1'b0;
        downloading <= 1'b0;
        repeat (4) @(posedge clk_sys);
    endtask

    task automatic report_test(input string name, input int mark);
        repeat (3) @(posedge clk_sys);
        n_tests++;
        if (err_cnt == mark) begin
            $display("test %s: ok", name);
        end else begin
            n_failed++;
            $display("test %s: %0d errors", name, err_cnt - mark);
        end
    endtask

    initial begin
        int mark;
        status           = '0;
        hdmi_width       = '0;
        hdmi_height      = '0;
        direct_video     = 1'b0;
        force_scan2x     = 1'b0;
        rotate_en        = 1'b0;
        ps2_mouse        = '0;
        user_in          = '1;
        game_tx          = 1'b1;
        cheat_tx         = 1'b1;
        downloading      = 1'b0;
        ddrld_burstcnt   = '0;
        ddrld_addr       = '0;
        ddrld_rd         = 1'b0;
        rot_burstcnt     = '0;
        rot_addr         = '0;
        rot_rd           = 1'b0;
        rot_we           = 1'b0;
        rot_be           = '0;
        ddram_busy       = 1'b0;
        ddram_dout_ready = 1'b0;
        @(posedge rst_n);
        @(posedge clk_sys);
        mark = err_cnt;
        test_crop();
        report_test("crop", mark);
        mark = err_cnt;
        test_vcopt();
        report_test("vcopt", mark);
        mark = err_cnt;
        test_user();
        report_test("user port", mark);
        mark = err_cnt;
        test_mouse();
        report_test("mouse", mark);
        mark = err_cnt;
        test_arb();
        report_test("arbiter", mark);
        $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk_sys);
        $display("timeout, tests still running after %0d cycles", WD_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/crop_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module crop_ctrl (
    input  wire                           clk_sys,
    input  wire                           rst_n,
    input  wire [mr_pkg::STATUS_W-1:0]    status,
    input  wire [mr_pkg::HDMI_W_W-1:0]    hdmi_width,
    input  wire [mr_pkg::HDMI_W_W-1:0]    hdmi_height,
    input  wire                           direct_video,
    input  wire                           force_scan2x,
    input  wire                           rotate_en,
    output logic                          crop_ok,
    output logic [mr_pkg::HDMI_W_W-1:0]   crop_size,
    output logic [4:0]                    crop_off
);

    // OSD fields
    logic       crop_en;
    logic [3:0] vcopt;
    logic [1:0] crop_scale;
    logic [2:0] scan_fx;
    logic       full_hd;
    logic       crop_allowed;
    logic [4:0] vcopt_x2;

    assign crop_en    = status[mr_pkg::ST_CROP_EN];
    assign vcopt      = status[mr_pkg::ST_VCOPT_HI:mr_pkg::ST_VCOPT_LO];
    assign crop_scale = status[mr_pkg::ST_CROP_SCALE_HI:mr_pkg::ST_CROP_SCALE_LO];
    assign scan_fx    = status[mr_pkg::ST_SCANFX_HI:mr_pkg::ST_SCANFX_LO];

    assign full_hd = (hdmi_width == mr_pkg::HDMI_FULL_W) &&
                     (hdmi_height == mr_pkg::HDMI_FULL_H);

    // Any scaler or rotation mode rules the crop out
    assign crop_allowed = full_hd &&
                          (scan_fx == 3'd0) &&
                          !force_scan2x &&
                          (crop_scale == 2'd0) &&
                          !direct_video &&
                          !rotate_en;

    // Offset step is two lines
    assign vcopt_x2 = {vcopt, 1'b0};

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            crop_ok   <= 1'b0;
            crop_size <= '0;
            crop_off  <= '0;
        end else begin
            crop_ok <= crop_allowed;
            // Size follows the crop_ok of the previous cycle
            if (crop_ok && crop_en) begin
                crop_size <= mr_pkg::CROP_LINES;
            end else begin
                crop_size <= '0;
            end
            // Upper options give negative offsets in 5-bit two's complement
            if (vcopt < mr_pkg::CROP_VCOPT_MAX) begin
                crop_off <= vcopt_x2;
            end else begin
                crop_off <= vcopt_x2 - mr_pkg::CROP_WRAP;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/mr_frame.sv
`timescale 1ns/10ps
`default_nettype none

module mr_frame #(
    parameter int AW = mr_pkg::DDR_AW,
    parameter int BW = mr_pkg::BURST_W
) (
    input  wire                         clk_sys,
    input  wire                         rst_n,
    // Crop settings
    input  wire [mr_pkg::STATUS_W-1:0]  status,
    input  wire [mr_pkg::HDMI_W_W-1:0]  hdmi_width,
    input  wire [mr_pkg::HDMI_W_W-1:0]  hdmi_height,
    input  wire                         direct_video,
    input  wire                         force_scan2x,
    input  wire                         rotate_en,
    output wire                         crop_ok,
    output wire [mr_pkg::HDMI_W_W-1:0]  crop_size,
    output wire [4:0]                   crop_off,
    // Mouse
    input  wire [24:0]                  ps2_mouse,
    output wire [8:0]                   mouse_dx,
    output wire [8:0]                   mouse_dy,
    output wire [7:0]                   mouse_f,
    output wire                         mouse_st,
    // User port
    input  wire [mr_pkg::USER_W-1:0]    user_in,
    input  wire                         game_tx,
    input  wire                         cheat_tx,
    output wire [mr_pkg::USER_W-1:0]    user_out,
    output wire                         game_rx,
    // Loader
    input  wire                         downloading,
    input  wire [BW-1:0]                ddrld_burstcnt,
    input  wire [AW-1:0]                ddrld_addr,
    input  wire                         ddrld_rd,
    output wire                         ddrld_busy,
    // Rotation
    input  wire [BW-1:0]                rot_burstcnt,
    input  wire [AW-1:0]                rot_addr,
    input  wire                         rot_rd,
    input  wire                         rot_we,
    input  wire [mr_pkg::DDR_DW/8-1:0]  rot_be,
    output wire                         rot_busy,
    // DDR3
    output wire [BW-1:0]                ddram_burstcnt,
    output wire [AW-1:0]                ddram_addr,
    output wire                         ddram_rd,
    output wire                         ddram_we,
    output wire [mr_pkg::DDR_DW/8-1:0]  ddram_be,
    input  wire                         ddram_busy,
    input  wire                         ddram_dout_ready
);

    wire uart_en;

    assign uart_en = status[mr_pkg::ST_UART_EN];

    burst_if #(.BW(BW)) u_bif ();

    assign u_bif.dout_ready = ddram_dout_ready;

    crop_ctrl u_crop (
        .clk_sys      ( clk_sys      ),
        .rst_n        ( rst_n        ),
        .status       ( status       ),
        .hdmi_width   ( hdmi_width   ),
        .hdmi_height  ( hdmi_height  ),
        .direct_video ( direct_video ),
        .force_scan2x ( force_scan2x ),
        .rotate_en    ( rotate_en    ),
        .crop_ok      ( crop_ok      ),
        .crop_size    ( crop_size    ),
        .crop_off     ( crop_off     )
    );

    player_io u_player (
        .clk_sys   ( clk_sys   ),
        .rst_n     ( rst_n     ),
        .ps2_mouse ( ps2_mouse ),
        .uart_en   ( uart_en   ),
        .user_in   ( user_in   ),
        .game_tx   ( game_tx   ),
        .cheat_tx  ( cheat_tx  ),
        .mouse_dx  ( mouse_dx  ),
        .mouse_dy  ( mouse_dy  ),
        .mouse_f   ( mouse_f   ),
        .mouse_st  ( mouse_st  ),
        .user_out  ( user_out  ),
        .game_rx   ( game_rx   )
    );

    ddr_arb_fsm #(.AW(AW), .BW(BW)) u_arb (
        .clk_sys        ( clk_sys        ),
        .rst_n          ( rst_n          ),
        .downloading    ( downloading    ),
        .ddrld_burstcnt ( ddrld_burstcnt ),
        .ddrld_addr     ( ddrld_addr     ),
        .ddrld_rd       ( ddrld_rd       ),
        .ddrld_busy     ( ddrld_busy     ),
        .rot_burstcnt   ( rot_burstcnt   ),
        .rot_addr       ( rot_addr       ),
        .rot_rd         ( rot_rd         ),
        .rot_we         ( rot_we         ),
        .rot_be         ( rot_be         ),
        .rot_busy       ( rot_busy       ),
        .ddram_busy     ( ddram_busy     ),
        .ddram_burstcnt ( ddram_burstcnt ),
        .ddram_addr     ( ddram_addr     ),
        .ddram_rd       ( ddram_rd       ),
        .ddram_we       ( ddram_we       ),
        .ddram_be       ( ddram_be       ),
        .bif            ( u_bif.fsm      )
    );

    ddr_burst_cnt #(.BW(BW)) u_bcnt (
        .clk_sys ( clk_sys   ),
        .rst_n   ( rst_n     ),
        .bif     ( u_bif.cnt )
    );

endmodule

`default_nettype wire

//--- hdl/player_io.sv
`timescale 1ns/10ps
`default_nettype none

module player_io (
    input  wire                         clk_sys,
    input  wire                         rst_n,
    input  wire [24:0]                  ps2_mouse,
    input  wire                         uart_en,
    input  wire [mr_pkg::USER_W-1:0]    user_in,
    input  wire                         game_tx,
    input  wire                         cheat_tx,
    output logic [8:0]                  mouse_dx,
    output logic [8:0]                  mouse_dy,
    output logic [7:0]                  mouse_f,
    output logic                        mouse_st,
    output logic [mr_pkg::USER_W-1:0]   user_out,
    output logic                        game_rx
);

    logic toggle_l;
    logic new_pkt;

    // Bit 24 flips once per packet
    assign new_pkt = ps2_mouse[24] ^ toggle_l;

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            toggle_l <= 1'b0;
            mouse_st <= 1'b0;
        end else begin
            toggle_l <= ps2_mouse[24];
            mouse_st <= new_pkt;
        end
    end

    // Movement bytes get their sign from the flag byte
    always_ff @(posedge clk_sys) begin
        if (new_pkt) begin
            mouse_f  <= ps2_mouse[7:0];
            mouse_dx <= {ps2_mouse[4], ps2_mouse[15:8]};
            mouse_dy <= {ps2_mouse[5], ps2_mouse[23:16]};
        end
    end

    // Game and cheat UARTs share the TX line
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            user_out <= mr_pkg::USER_IDLE;
        end else if (uart_en) begin
            user_out <= {{(mr_pkg::USER_W-1){1'b1}}, game_tx & cheat_tx};
        end else begin
            user_out <= mr_pkg::USER_IDLE;
        end
    end

    assign game_rx = uart_en ? user_in[1] : 1'b1;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_mr_frame -f verilog.f &&
out=$(./obj_dir/Vtb_mr_frame)
echo "$out"
echo "$out" | grep -qxF '** PASS **' && echo "simulation ok" ||
{ echo "simulation failed"; exit 1; }

//--- verilog.f
common/mr_pkg.sv
common/burst_if.sv
hdl/crop_ctrl.sv
hdl/player_io.sv
ddr_arb/ddr_arb_fsm.sv
ddr_arb/ddr_burst_cnt.sv
hdl/mr_frame.sv
dv/tb_clkgen.sv
dv/tb_mr_frame.sv
